//--- hw/cl_encode_config.svh
// **************************************************
// Sizes and Deflate run limits for the code-length
// table encoder. Include it wherever a macro is used.
// **************************************************
`ifndef CL_ENCODE_CONFIG_SVH
`define CL_ENCODE_CONFIG_SVH

`define CL_MAX_LIT        286  // Literal/length code lengths.
`define CL_MAX_DIST       30   // Distance code lengths.
`define CL_TABLE_DEPTH    316
`define CL_ADDR_W         9
`define CL_MIN_LIT_CODES  257  // HLIT base.

// Run bounds per repeat symbol.
`define CL_REP_MIN        3
`define CL_REP_MAX        6
`define CL_Z3_MIN         3
`define CL_Z3_MAX         10
`define CL_Z7_MIN         11
`define CL_Z7_MAX         138

`endif

//--- hw/cl_symbol_pkg.sv
// **************************************************
// Types of the Deflate code-length alphabet and of
// one entry in the output symbol table.
// **************************************************
`default_nettype none

package cl_symbol_pkg;

  typedef logic [3:0] cl_len_t;  // One code length, 0 to 15.
  typedef logic [4:0] cl_sym_t;  // One code-length symbol, 0 to 18.

  localparam cl_sym_t SYM_REPEAT = 5'd16;  // Repeat previous length.
  localparam cl_sym_t SYM_ZERO3  = 5'd17;
  localparam cl_sym_t SYM_ZERO7  = 5'd18;

  // Symbol with its extra bits, as stored in the output table.
  typedef struct packed {
    cl_sym_t    sym;
    logic [6:0] extra_val;
    logic [2:0] extra_len;  // Zero for literal lengths.
  } sym_entry_t;

endpackage

`default_nettype wire

//--- hw/cl_ctrl_pkg.sv
// **************************************************
// Control types of the encoder: table index, run
// counter and the sequencing states.
// **************************************************
`default_nettype none

`include "cl_encode_config.svh"

package cl_ctrl_pkg;

  typedef logic [`CL_ADDR_W-1:0] tbl_idx_t;
  typedef logic [7:0]            run_cnt_t;  // Holds up to a full 18 run.

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/table_ram.sv
// **************************************************
// Simple dual-port table with a registered read.
// The entry type is set per instance.
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module table_ram #(
  parameter type entry_t = logic [7:0],
  parameter int  depth   = 16,
  parameter int  addr_w  = 4
) (
  input  logic              clk_gated,
  input  logic              wr_en,
  input  logic [addr_w-1:0] wr_addr,
  input  entry_t            wr_data,
  input  logic [addr_w-1:0] rd_addr,
  output entry_t            rd_data
);

  entry_t mem [depth];

  always_ff @(posedge clk_gated)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];  // Data one cycle after the address.
  end

  // The address range is wider than the table.
  a_wr_in_range: assert property (
    @(posedge clk_gated) wr_en |-> (wr_addr < depth)
  );

endmodule

`default_nettype wire

//--- hw/cl_fetch.sv
// **************************************************
// Reads the length table in order and hands one length
// per cycle to the run encoder, with table-end marks.
// Under enc_hold the current item is read again.
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module cl_fetch (
  input  logic                   clk_gated,
  input  logic                   rst_n,
  input  logic                   fetch_go,
  input  cl_ctrl_pkg::tbl_idx_t  last_lit_idx,
  input  cl_ctrl_pkg::tbl_idx_t  last_idx,
  input  logic                   enc_hold,
  output cl_ctrl_pkg::tbl_idx_t  rd_addr,
  input  cl_symbol_pkg::cl_len_t rd_data,
  output logic                   cl_valid,
  output cl_symbol_pkg::cl_len_t cl_len,
  output logic                   cl_tbl_end
);

  import cl_ctrl_pkg::*;

  tbl_idx_t ptr;       // Next index to read.
  tbl_idx_t cur_idx;   // Index of the item now on cl_len.
  tbl_idx_t next_idx;
  logic     active;
  logic     rd_en;
  logic     hold_item;

  assign hold_item = enc_hold && cl_valid;
  assign next_idx  = fetch_go ? '0 : ptr;
  assign rd_en     = (fetch_go || active) && !enc_hold;
  assign rd_addr   = hold_item ? cur_idx : next_idx;  // Replay while held.

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ptr      <= '0;
      cur_idx  <= '0;
      active   <= 1'b0;
      cl_valid <= 1'b0;
    end
    else
    begin
      if (rd_en)
      begin
        ptr    <= next_idx + 1'b1;
        active <= (next_idx != last_idx);
      end
      if (!hold_item)
      begin
        cl_valid <= rd_en;
        cur_idx  <= next_idx;
      end
    end
  end

  // Read data lines up with the registered valid.
  assign cl_len     = rd_data;
  assign cl_tbl_end = cl_valid && ((cur_idx == last_lit_idx) || (cur_idx == last_idx));

endmodule

`default_nettype wire

//--- hw/cl_run_encoder.sv
// **************************************************
// Run-length encodes code lengths into Deflate symbols
// 0-18 and writes them to the symbol table. Runs stop
// at each table end. Holds the fetch while it flushes.
// **************************************************
`timescale 1ns/1ps
`default_nettype none

`include "cl_encode_config.svh"

module cl_run_encoder (
  input  logic                      clk_gated,
  input  logic                      rst_n,
  input  logic                      enc_clear,
  input  logic                      cl_valid,
  input  cl_symbol_pkg::cl_len_t    cl_len,
  input  logic                      cl_tbl_end,
  output logic                      enc_hold,
  output logic                      sym_wr_en,
  output cl_ctrl_pkg::tbl_idx_t     sym_wr_addr,
  output cl_symbol_pkg::sym_entry_t sym_wr_data,
  output cl_ctrl_pkg::tbl_idx_t     sym_count,
  output logic [10:0]               extra_bits,
  output logic                      enc_flushed
);

  import cl_symbol_pkg::*;
  import cl_ctrl_pkg::*;

  cl_len_t    run_val;
  run_cnt_t   run_cnt;      // Lengths of the run not yet emitted.
  run_cnt_t   run_cnt_nxt;
  logic       run_open;
  logic       closing;      // Table ended, run must drain.
  logic       tbl_seen;     // First table already closed.
  logic       joins;
  logic       take;
  logic       step;
  logic       emit;
  sym_entry_t entry;

  assign joins    = cl_valid && run_open && (cl_len == run_val);
  assign enc_hold = closing || (cl_valid && !joins && (run_cnt != '0));
  assign take     = cl_valid && !enc_hold;
  assign step     = enc_hold && (run_cnt != '0);  // One flush symbol.

  always_comb
  begin
    emit        = 1'b0;
    entry       = '0;
    run_cnt_nxt = run_cnt;
    if (step)
    begin
      emit        = 1'b1;
      run_cnt_nxt = '0;
      if (run_val == '0 && run_cnt >= `CL_Z7_MIN)
      begin
        entry.sym       = SYM_ZERO7;
        entry.extra_val = 7'(run_cnt - `CL_Z7_MIN);
        entry.extra_len = 3'd7;
      end
      else if (run_val == '0 && run_cnt >= `CL_Z3_MIN && run_cnt <= `CL_Z3_MAX)
      begin
        entry.sym       = SYM_ZERO3;
        entry.extra_val = 7'(run_cnt - `CL_Z3_MIN);
        entry.extra_len = 3'd3;
      end
      else if (run_val != '0 && run_cnt >= `CL_REP_MIN)
      begin
        entry.sym       = SYM_REPEAT;
        entry.extra_val = 7'(run_cnt - `CL_REP_MIN);
        entry.extra_len = 3'd2;
      end
      else
      begin
        entry.sym   = {1'b0, run_val};  // Short leftover goes out literally.
        run_cnt_nxt = run_cnt - 8'd1;
      end
    end
    else if (take)
    begin
      if (joins)
      begin
        run_cnt_nxt = run_cnt + 8'd1;
        if (run_val == '0 && run_cnt_nxt == `CL_Z7_MAX)
        begin
          emit            = 1'b1;
          entry.sym       = SYM_ZERO7;
          entry.extra_val = 7'(`CL_Z7_MAX - `CL_Z7_MIN);
          entry.extra_len = 3'd7;
          run_cnt_nxt     = '0;
        end
        else if (run_val != '0 && run_cnt_nxt == `CL_REP_MAX)
        begin
          emit            = 1'b1;
          entry.sym       = SYM_REPEAT;
          entry.extra_val = 7'(`CL_REP_MAX - `CL_REP_MIN);
          entry.extra_len = 3'd2;
          run_cnt_nxt     = '0;
        end
      end
      else if (cl_len != '0)
      begin
        emit        = 1'b1;  // First of a nonzero run is literal.
        entry.sym   = {1'b0, cl_len};
        run_cnt_nxt = '0;
      end
      else
      begin
        run_cnt_nxt = 8'd1;
      end
    end
  end

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      run_cnt     <= '0;
      run_open    <= 1'b0;
      closing     <= 1'b0;
      tbl_seen    <= 1'b0;
      sym_wr_en   <= 1'b0;
      sym_count   <= '0;
      extra_bits  <= '0;
      enc_flushed <= 1'b0;
    end
    else if (enc_clear)
    begin
      run_cnt     <= '0;
      run_open    <= 1'b0;
      closing     <= 1'b0;
      tbl_seen    <= 1'b0;
      sym_wr_en   <= 1'b0;
      sym_count   <= '0;
      extra_bits  <= '0;
      enc_flushed <= 1'b0;
    end
    else
    begin
      run_cnt     <= run_cnt_nxt;
      sym_wr_en   <= emit;
      enc_flushed <= 1'b0;
      if (emit)
      begin
        sym_count  <= sym_count + 1'b1;
        extra_bits <= extra_bits + 11'(entry.extra_len);
      end
      if (take && !joins)
      begin
        run_open <= 1'b1;
      end
      if (take && cl_tbl_end)
      begin
        closing <= 1'b1;
      end
      if (closing && run_cnt == '0)
      begin
        closing     <= 1'b0;
        run_open    <= 1'b0;            // Next table starts a fresh run.
        tbl_seen    <= !tbl_seen;
        enc_flushed <= tbl_seen;
      end
    end
  end

  always_ff @(posedge clk_gated)
  begin
    if (take && !joins)
    begin
      run_val <= cl_len;
    end
    if (emit)
    begin
      sym_wr_data <= entry;
      sym_wr_addr <= sym_count;
    end
  end

  a_run_cnt_max: assert property (
    @(posedge clk_gated) disable iff (!rst_n) run_cnt <= `CL_Z7_MAX
  );

  // A held item must come back unchanged from the fetch.
  a_hold_replays: assert property (
    @(posedge clk_gated) disable iff (!rst_n || enc_clear)
    (cl_valid && enc_hold) |=> (cl_valid && $stable(cl_len) && $stable(cl_tbl_end))
  );

endmodule

`default_nettype wire

//--- hw/cl_encode_ctrl.sv
// **************************************************
// Start/busy/done sequencing of one encode job, and
// the HLIT, HDIST and table-limit registers.
// **************************************************
`timescale 1ns/1ps
`default_nettype none

`include "cl_encode_config.svh"

module cl_encode_ctrl (
  input  logic                  clk_gated,
  input  logic                  rst_n,
  input  logic                  start,
  input  cl_ctrl_pkg::tbl_idx_t sym_hi_a,
  input  cl_ctrl_pkg::tbl_idx_t sym_hi_b,
  input  logic                  enc_flushed,
  output logic                  fetch_go,
  output logic                  enc_clear,
  output cl_ctrl_pkg::tbl_idx_t last_lit_idx,
  output cl_ctrl_pkg::tbl_idx_t last_idx,
  output logic                  busy,
  output logic                  done,
  output logic [4:0]            hlit,
  output logic [4:0]            hdist
);

  import cl_ctrl_pkg::*;

  ctrl_state_t state;
  logic        launch;

  assign launch = start && !busy;  // Start while busy is dropped.

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= IDLE;
      last_lit_idx <= '0;
      last_idx     <= '0;
      hlit         <= '0;
      hdist        <= '0;
    end
    else
    begin
      case (state)
        IDLE, DONE:
          state <= launch ? RUN : IDLE;
        RUN:
          state <= DRAIN;                  // Fetch and encoder started.
        DRAIN:
          state <= enc_flushed ? DONE : DRAIN;
        default:
          state <= IDLE;
      endcase
      if (launch)
      begin
        last_lit_idx <= sym_hi_a;
        last_idx     <= sym_hi_a + sym_hi_b + 1'b1;  // Distances follow literals.
        hdist        <= sym_hi_b[4:0];
        if (sym_hi_a >= tbl_idx_t'(`CL_MIN_LIT_CODES - 1))
          hlit <= 5'(sym_hi_a + 1 - `CL_MIN_LIT_CODES);
        else
          hlit <= '0;
      end
    end
  end

  assign fetch_go  = (state == RUN);
  assign enc_clear = (state == RUN);
  assign busy      = (state == RUN) || (state == DRAIN);
  assign done      = (state == DONE);

  a_done_not_busy: assert property (
    @(posedge clk_gated) disable iff (!rst_n) !(done && busy)
  );

  // The encoder only finishes a job that this block is waiting on.
  a_flush_in_drain: assert property (
    @(posedge clk_gated) disable iff (!rst_n) enc_flushed |-> (state == DRAIN)
  );

endmodule

`default_nettype wire

//--- hw/cl_encode_top.sv
// **************************************************
// Code-length table encoder top. Host fills the length
// table, pulses start, waits for done, then reads the
// symbol table and the summary outputs.
// **************************************************
`timescale 1ns/1ps
`default_nettype none

`include "cl_encode_config.svh"

module cl_encode_top (
  input  logic                      clk_gated,
  input  logic                      rst_n,
  input  logic                      cl_wr_en,
  input  cl_ctrl_pkg::tbl_idx_t     cl_wr_addr,
  input  cl_symbol_pkg::cl_len_t    cl_wr_data,
  input  logic                      start,
  input  cl_ctrl_pkg::tbl_idx_t     sym_hi_a,
  input  cl_ctrl_pkg::tbl_idx_t     sym_hi_b,
  output logic                      busy,
  output logic                      done,
  output logic [4:0]                hlit,
  output logic [4:0]                hdist,
  output cl_ctrl_pkg::tbl_idx_t     sym_count,
  output logic [10:0]               extra_bits,
  input  cl_ctrl_pkg::tbl_idx_t     sym_rd_addr,
  output cl_symbol_pkg::sym_entry_t sym_rd_data
);

  import cl_symbol_pkg::*;
  import cl_ctrl_pkg::*;

  tbl_idx_t   cl_rd_addr;
  cl_len_t    cl_rd_data;
  tbl_idx_t   last_lit_idx;
  tbl_idx_t   last_idx;
  logic       fetch_go;
  logic       enc_clear;
  logic       enc_hold;
  logic       enc_flushed;
  logic       cl_valid;
  cl_len_t    cl_len;
  logic       cl_tbl_end;
  logic       sym_wr_en;
  tbl_idx_t   sym_wr_addr;
  sym_entry_t sym_wr_data;

  table_ram #(
    .entry_t (cl_len_t),
    .depth   (`CL_MAX_LIT + `CL_MAX_DIST),
    .addr_w  (`CL_ADDR_W)
  ) cl_table (
    .clk_gated (clk_gated),
    .wr_en     (cl_wr_en),
    .wr_addr   (cl_wr_addr),
    .wr_data   (cl_wr_data),
    .rd_addr   (cl_rd_addr),
    .rd_data   (cl_rd_data)
  );

  table_ram #(
    .entry_t (sym_entry_t),
    .depth   (`CL_TABLE_DEPTH),
    .addr_w  (`CL_ADDR_W)
  ) sym_table (
    .clk_gated (clk_gated),
    .wr_en     (sym_wr_en),
    .wr_addr   (sym_wr_addr),
    .wr_data   (sym_wr_data),
    .rd_addr   (sym_rd_addr),
    .rd_data   (sym_rd_data)
  );

  cl_fetch u_fetch (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .fetch_go     (fetch_go),
    .last_lit_idx (last_lit_idx),
    .last_idx     (last_idx),
    .enc_hold     (enc_hold),
    .rd_addr      (cl_rd_addr),
    .rd_data      (cl_rd_data),
    .cl_valid     (cl_valid),
    .cl_len       (cl_len),
    .cl_tbl_end   (cl_tbl_end)
  );

  cl_run_encoder u_encoder (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .enc_clear   (enc_clear),
    .cl_valid    (cl_valid),
    .cl_len      (cl_len),
    .cl_tbl_end  (cl_tbl_end),
    .enc_hold    (enc_hold),
    .sym_wr_en   (sym_wr_en),
    .sym_wr_addr (sym_wr_addr),
    .sym_wr_data (sym_wr_data),
    .sym_count   (sym_count),
    .extra_bits  (extra_bits),
    .enc_flushed (enc_flushed)
  );

  cl_encode_ctrl u_ctrl (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .start        (start),
    .sym_hi_a     (sym_hi_a),
    .sym_hi_b     (sym_hi_b),
    .enc_flushed  (enc_flushed),
    .fetch_go     (fetch_go),
    .enc_clear    (enc_clear),
    .last_lit_idx (last_lit_idx),
    .last_idx     (last_idx),
    .busy         (busy),
    .done         (done),
    .hlit         (hlit),
    .hdist        (hdist)
  );

endmodule

`default_nettype wire

//--- verification/cl_encode_ref.svh
// **************************************************
// Reference Deflate code-length encoder for the
// testbench. Include it inside the testbench module.
// **************************************************
`ifndef CL_ENCODE_REF_SVH
`define CL_ENCODE_REF_SVH

// Symbol, extra value, extra length, packed as in the symbol table.
function automatic logic [14:0] pack_entry(input int sym, input int val, input int len);
  return {5'(sym), 7'(val), 3'(len)};
endfunction

// Run-length encodes literal lengths src[0..n_lit-1], then the distance lengths.
function automatic void encode_lengths(input int src[$], input int n_lit,
                                       output logic [14:0] syms[$], output int extra);
  int i;
  int v;
  int n;
  int r;
  int last;
  syms  = {};
  extra = 0;
  i     = 0;
  while (i < src.size())
  begin
    v    = src[i];
    last = (i < n_lit) ? n_lit : src.size();  // Runs stop at the table end.
    n    = 1;
    while (i + n < last && src[i + n] == v)
      n++;
    i += n;
    if (v == 0)
    begin
      while (n >= 11)
      begin
        r = (n > 138) ? 138 : n;
        syms.push_back(pack_entry(18, r - 11, 7));
        extra += 7;
        n     -= r;
      end
      if (n >= 3)
      begin
        syms.push_back(pack_entry(17, n - 3, 3));
        extra += 3;
        n      = 0;
      end
    end
    else
    begin
      syms.push_back(pack_entry(v, 0, 0));  // First of the run.
      n--;
      while (n >= 3)
      begin
        r = (n > 6) ? 6 : n;
        syms.push_back(pack_entry(16, r - 3, 2));
        extra += 2;
        n     -= r;
      end
    end
    repeat (n) syms.push_back(pack_entry(v, 0, 0));
  end
endfunction

// HLIT is the literal count minus 257, never below zero.
function automatic int expected_hlit(input int hi_a);
  return (hi_a + 1 > 257) ? hi_a + 1 - 257 : 0;
endfunction

`endif

//--- verification/cl_encode_tb.sv
// **************************************************
// Testbench for the code-length table encoder. Runs
// directed and random jobs, then checks symbols,
// counts and header fields against a reference model.
// **************************************************
`timescale 1ns/1ps
`default_nettype none

`include "cl_encode_config.svh"

module cl_encode_tb;

  import cl_symbol_pkg::*;
  import cl_ctrl_pkg::*;

  localparam int num_jobs   = 18;
  localparam int max_cycles = num_jobs * `CL_TABLE_DEPTH * 4 + 2000;

  logic        clk_gated;
  logic        rst_n;
  logic        cl_wr_en;
  tbl_idx_t    cl_wr_addr;
  cl_len_t     cl_wr_data;
  logic        start;
  tbl_idx_t    sym_hi_a;
  tbl_idx_t    sym_hi_b;
  logic        busy;
  logic        done;
  logic [4:0]  hlit;
  logic [4:0]  hdist;
  tbl_idx_t    sym_count;
  logic [10:0] extra_bits;
  tbl_idx_t    sym_rd_addr;
  sym_entry_t  sym_rd_data;

  int          lens[$];      // Literal lengths, then distance lengths.
  logic [14:0] exp_syms[$];
  int          exp_extra;
  integer      seed;
  int          done_cnt;
  int          jobs_run;
  int          req_cnt;
  int          ack_cnt;
  int          stim_errors;
  int          cmp_errors;
  int          mon_errors;
  int          tests_passed;
  int          tests_failed;
  string       test_name;

  `include "cl_encode_ref.svh"

  cl_encode_top UUT (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .cl_wr_en    (cl_wr_en),
    .cl_wr_addr  (cl_wr_addr),
    .cl_wr_data  (cl_wr_data),
    .start       (start),
    .sym_hi_a    (sym_hi_a),
    .sym_hi_b    (sym_hi_b),
    .busy        (busy),
    .done        (done),
    .hlit        (hlit),
    .hdist       (hdist),
    .sym_count   (sym_count),
    .extra_bits  (extra_bits),
    .sym_rd_addr (sym_rd_addr),
    .sym_rd_data (sym_rd_data)
  );

  initial
  begin
    clk_gated = 1'b0;
    forever #10 clk_gated = ~clk_gated;
  end

  initial
  begin
    repeat (max_cycles) @(posedge clk_gated);
    $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // Done is a one-cycle pulse and never overlaps busy.
  always @(negedge clk_gated)
  begin
    if (rst_n)
    begin
      if (done)
        done_cnt++;
      assert (!(done && busy))
      else
      begin
        $display("Error in %s: busy and done were high together at %0t", test_name, $time);
        mon_errors++;
      end
    end
  end

  function automatic void add_run(input int v, input int n);
    repeat (n) lens.push_back(v);
  endfunction

  // Biased toward zeros and repeats so that runs form.
  function automatic void add_random(input int n);
    int v;
    repeat (n)
    begin
      if (lens.size() > 0 && $unsigned($random(seed)) % 3 != 0)
        v = lens[lens.size() - 1];
      else if ($unsigned($random(seed)) % 2 == 0)
        v = 0;
      else
        v = $unsigned($random(seed)) % 16;
      lens.push_back(v);
    end
  endfunction

  function automatic void check_value(input string what, input int exp, input int act);
    assert (exp == act)
    else
    begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      stim_errors++;
    end
  endfunction

  // Loads the tables, runs one job, checks the summary, then waits for the readback.
  task automatic run_job(input string name, input int hi_a, input int hi_b, input bit poke);
    int err_before;
    err_before = stim_errors + cmp_errors + mon_errors;
    test_name  = name;
    encode_lengths(lens, hi_a + 1, exp_syms, exp_extra);
    foreach (lens[i])
    begin
      @(negedge clk_gated);
      cl_wr_en   = 1'b1;
      cl_wr_addr = tbl_idx_t'(i);
      cl_wr_data = cl_len_t'(lens[i]);
    end
    @(negedge clk_gated);
    cl_wr_en = 1'b0;
    start    = 1'b1;
    sym_hi_a = tbl_idx_t'(hi_a);
    sym_hi_b = tbl_idx_t'(hi_b);
    @(negedge clk_gated);
    check_value("busy", 1, int'(busy));
    start    = poke;  // Lands while busy.
    sym_hi_a = '0;
    sym_hi_b = '0;
    @(negedge clk_gated);
    start = 1'b0;
    while (!done)
      @(negedge clk_gated);
    jobs_run++;
    check_value("sym_count", exp_syms.size(), int'(sym_count));
    check_value("extra_bits", exp_extra, int'(extra_bits));
    check_value("hlit", expected_hlit(hi_a), int'(hlit));
    check_value("hdist", hi_b, int'(hdist));
    req_cnt++;
    wait (ack_cnt == req_cnt);
    check_value("done pulses", jobs_run, done_cnt);
    if (stim_errors + cmp_errors + mon_errors == err_before)
    begin
      tests_passed++;
      $display("test %s: ok, %0d symbols", name, exp_syms.size());
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, stim_errors + cmp_errors + mon_errors - err_before);
    end
    lens = {};
  endtask

  // Reads the symbol table back, one address per cycle.
  initial
  begin : compare_symbols
    logic [14:0] got;
    int          n;
    int          k;
    sym_rd_addr = '0;
    ack_cnt     = 0;
    forever
    begin
      wait (req_cnt != ack_cnt);
      n = exp_syms.size();
      for (k = 0; k <= n; k++)
      begin
        @(negedge clk_gated);
        if (k > 0)
        begin
          got = sym_rd_data;
          assert (got === exp_syms[k - 1])
          else
          begin
            $display("MISMATCH %s entry %0d: expected %h, actual %h",
                     test_name, k - 1, exp_syms[k - 1], got);
            cmp_errors++;
          end
        end
        if (k < n)
          sym_rd_addr = tbl_idx_t'(k);
      end
      ack_cnt++;
    end
  end

  initial
  begin
    int i;
    int hi_a;
    int hi_b;
    seed       = 51731;
    rst_n      = 1'b0;
    cl_wr_en   = 1'b0;
    cl_wr_addr = '0;
    cl_wr_data = '0;
    start      = 1'b0;
    sym_hi_a   = '0;
    sym_hi_b   = '0;
    repeat (2) @(posedge clk_gated);
    @(negedge clk_gated);
    rst_n = 1'b1;

    for (i = 0; i < 25; i++)
      add_run((i < 20) ? i % 15 + 1 : i % 3, 1);  // No equal neighbours.
    run_job("all_literal", 19, 4, 1'b0);

    add_run(5, 1);
    add_run(0, 12);
    add_run(7, 1);
    add_run(0, 138);
    add_run(3, 1);
    add_run(1, 1);
    add_run(2, 1);
    run_job("zero_runs_12_138", 152, 1, 1'b0);
    add_run(0, 140);
    add_run(9, 1);
    add_run(0, 5);
    add_run(4, 1);
    add_run(0, 1);
    run_job("zero_runs_140_5", 146, 0, 1'b0);

    add_run(3, 2);
    add_run(6, 4);
    add_run(9, 7);
    add_run(12, 10);
    add_run(1, 1);
    add_run(8, 3);
    run_job("repeats", 23, 2, 1'b0);

    // Runs that continue across the literal/distance boundary.
    add_run(2, 1);
    add_run(0, 8);
    add_run(0, 6);
    add_run(5, 5);
    run_job("boundary_zero", 8, 10, 1'b0);
    add_run(2, 1);
    add_run(5, 4);
    add_run(5, 3);
    add_run(0, 6);
    run_job("boundary_repeat", 4, 8, 1'b0);

    add_random(257);
    run_job("header_0", 255, 0, 1'b1);
    add_random(287);
    run_job("header_1", 256, 29, 1'b1);
    add_random(275);
    run_job("header_2", 270, 3, 1'b1);
    add_random(316);
    run_job("header_3", 285, 29, 1'b1);

    for (i = 0; i < 8; i++)
    begin
      hi_a = $unsigned($random(seed)) % `CL_MAX_LIT;
      hi_b = $unsigned($random(seed)) % `CL_MAX_DIST;
      add_random(hi_a + hi_b + 2);
      run_job($sformatf("random_%0d", i), hi_a, hi_b, i[0]);
    end

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
+incdir+verification
hw/cl_symbol_pkg.sv
hw/cl_ctrl_pkg.sv
hw/table_ram.sv
hw/cl_fetch.sv
hw/cl_run_encoder.sv
hw/cl_encode_ctrl.sv
hw/cl_encode_top.sv
verification/cl_encode_tb.sv
